/* sim.f */
common/enet_pkg.sv
verilog/enet_regs.sv
verilog/enet_intr_coalesce.sv
mdio/enet_mdio.sv
verilog/enet_mgmt_core.sv
tb/tb_enet_mgmt_core.sv

/* Makefile */
# Verilator build and run of the Ethernet management core testbench

VERILATOR ?= verilator
TOP       ?= tb_enet_mgmt_core
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
PASS_MSG  := Testbench passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/tb_enet_mgmt_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_enet_mgmt_core;
    import enet_pkg::*;

    logic                  clk;
    logic                  rst_n;
    logic                  reg_wr;
    logic                  reg_rd;
    logic [REG_ADDR_W-1:0] reg_addr;
    logic [REG_DATA_W-1:0] reg_wdata;
    wire  [REG_DATA_W-1:0] reg_rdata;
    wire                   reg_rvalid;
    wire                   irq;
    logic                  tx_frame;
    logic                  rx_frame;
    wire                   mdc;
    logic                  mdi;
    wire                   mdo;
    wire                   mdo_en;

    int errors;
    int timeouts;

    // PHY model state
    logic        mdc_q;
    logic        mdo_en_q;
    logic        cap_bits[$];
    int          mdc_rises;
    time         last_rise;
    time         min_period;
    time         max_period;
    logic        phy_drive;
    int          fall_cnt;
    logic [15:0] phy_data;

    enet_mgmt_core UUT (
        .clk        (clk       ),
        .rst_n      (rst_n     ),
        .reg_wr     (reg_wr    ),
        .reg_rd     (reg_rd    ),
        .reg_addr   (reg_addr  ),
        .reg_wdata  (reg_wdata ),
        .reg_rdata  (reg_rdata ),
        .reg_rvalid (reg_rvalid),
        .irq        (irq       ),
        .tx_frame   (tx_frame  ),
        .rx_frame   (rx_frame  ),
        .mdc        (mdc       ),
        .mdi        (mdi       ),
        .mdo        (mdo       ),
        .mdo_en     (mdo_en    )
    );

    always #20 clk = ~clk;

    // a real PHY finds ST after the run of preamble ones, then reads OP
    function automatic logic read_opcode_seen();
        int s;
        s = 0;
        while (s < cap_bits.size() && cap_bits[s] == 1'b1) s++;
        return (s + 3 < cap_bits.size()) && cap_bits[s + 2] == 1'b1 && cap_bits[s + 3] == 1'b0;
    endfunction

    // MDIO PHY model, looks at the lines once per clk on the falling edge
    always @(negedge clk) begin
        if (mdo_en && !mdo_en_q) begin
            cap_bits.delete();
            last_rise  = 0;
            min_period = '1;
            max_period = 0;
        end
        if (mdc && !mdc_q) begin
            mdc_rises++;
            if (last_rise != 0) begin
                if ($time - last_rise < min_period) min_period = $time - last_rise;
                if ($time - last_rise > max_period) max_period = $time - last_rise;
            end
            last_rise = $time;
            if (mdo_en) cap_bits.push_back(mdo);
        end
        if (!mdc && mdc_q) begin
            if (mdo_en_q && !mdo_en && read_opcode_seen()) begin
                // host released the line, turnaround starts
                phy_drive = 1'b1;
                fall_cnt  = 0;
                phy_data  = 16'($urandom);
            end else if (phy_drive) begin
                fall_cnt++;
                if (fall_cnt >= 2 && fall_cnt <= 17) begin
                    mdi = phy_data[17 - fall_cnt];
                end else if (fall_cnt > 17) begin
                    phy_drive = 1'b0;
                    mdi       = 1'b1;
                end
            end
        end
        mdc_q    = mdc;
        mdo_en_q = mdo_en;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        errors++;
        $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, got);
    endtask

    task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [REG_DATA_W-1:0] data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_wr    = 1'b0;
    endtask

    task automatic read_reg(input logic [REG_ADDR_W-1:0] addr, output logic [REG_DATA_W-1:0] data);
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(negedge clk);
        reg_rd   = 1'b0;
        if (reg_rvalid !== 1'b1) report_mismatch("reg_rvalid", 32'd1, 32'(reg_rvalid));
        data = reg_rdata;
    endtask

    task automatic expect_reg(input logic [REG_ADDR_W-1:0] addr, input logic [REG_DATA_W-1:0] exp);
        logic [REG_DATA_W-1:0] d;
        read_reg(addr, d);
        if (d !== exp) report_mismatch($sformatf("reg_rdata @%h", addr), exp, d);
    endtask

    task automatic pulse_event(input logic rx);
        tx_frame = !rx;
        rx_frame = rx;
        @(negedge clk);
        tx_frame = 1'b0;
        rx_frame = 1'b0;
    endtask

    // cycle model of EIR, W1C and irq under random strobes
    task automatic run_eir_random(input int cycles, input logic [31:0] eimr_val);
        logic [31:0] m_eir;
        logic [31:0] m_set;
        logic [31:0] ev_prev;
        logic [31:0] clr_prev;
        logic [31:0] exp_rd;
        logic        exp_irq;
        logic        rd_pending;
        m_eir      = '0;
        m_set      = '0;
        ev_prev    = '0;
        clr_prev   = '0;
        exp_rd     = '0;
        rd_pending = 1'b0;
        repeat (cycles) begin
            if (rd_pending) begin
                if (reg_rvalid !== 1'b1) report_mismatch("reg_rvalid", 32'd1, 32'(reg_rvalid));
                if (reg_rdata !== exp_rd) report_mismatch("reg_rdata EIR", exp_rd, reg_rdata);
            end else if (reg_rvalid !== 1'b0) begin
                report_mismatch("reg_rvalid", 32'd0, 32'(reg_rvalid));
            end
            exp_irq  = |(m_eir & eimr_val);
            m_eir    = m_set | (m_eir & ~clr_prev);
            m_set    = ev_prev;
            if (irq !== exp_irq) report_mismatch("irq", 32'(exp_irq), 32'(irq));
            reg_wr     = 1'b0;
            reg_rd     = 1'b0;
            clr_prev   = '0;
            rd_pending = 1'b0;
            tx_frame   = ($urandom_range(0, 3) == 0);
            rx_frame   = ($urandom_range(0, 3) == 0);
            ev_prev    = '0;
            ev_prev[EIR_TXF_BIT] = tx_frame;
            ev_prev[EIR_RXF_BIT] = rx_frame;
            case ($urandom_range(0, 3))
                1: begin
                    reg_wr    = 1'b1;
                    reg_addr  = ADDR_EIR;
                    reg_wdata = $urandom;
                    clr_prev  = reg_wdata;
                end
                2: begin
                    reg_rd     = 1'b1;
                    reg_addr   = ADDR_EIR;
                    rd_pending = 1'b1;
                    exp_rd     = m_eir;
                end
                default: ;
            endcase
            @(negedge clk);
        end
        tx_frame = 1'b0;
        rx_frame = 1'b0;
        reg_wr   = 1'b0;
        reg_rd   = 1'b0;
        repeat (3) @(negedge clk);
        write_reg(ADDR_EIR, '1);
        expect_reg(ADDR_EIR, '0);
    endtask

    task automatic check_count_coalesce(input logic rx);
        int                    n;
        int                    bitpos;
        logic [REG_ADDR_W-1:0] ic_addr;
        logic [REG_DATA_W-1:0] d;
        ic_addr = rx ? ADDR_RXIC : ADDR_TXIC;
        bitpos  = rx ? EIR_RXF_BIT : EIR_TXF_BIT;
        n       = $urandom_range(1, 12);
        write_reg(ic_addr, (32'd1 << IC_EN_BIT) | (32'(n) << IC_CNT_LSB));
        repeat (n - 1) begin
            pulse_event(rx);
            repeat ($urandom_range(0, 3)) @(negedge clk);
        end
        repeat (3) @(negedge clk);
        read_reg(ADDR_EIR, d);
        if (d[bitpos] !== 1'b0) report_mismatch("EIR event bit before threshold", 0, 1);
        pulse_event(rx);
        read_reg(ADDR_EIR, d);
        if (d[bitpos] !== 1'b0) report_mismatch("EIR event bit one cycle after", 0, 1);
        read_reg(ADDR_EIR, d);
        if (d[bitpos] !== 1'b1) report_mismatch("EIR event bit two cycles after", 1, 0);
        write_reg(ic_addr, '0);
        write_reg(ADDR_EIR, '1);
    endtask

    task automatic check_timer_coalesce();
        int                    t;
        int                    j;
        logic [REG_DATA_W-1:0] d;
        t = $urandom_range(1, 40);
        write_reg(ADDR_RXIC, (32'd1 << IC_EN_BIT) | (32'd255 << IC_CNT_LSB) | 32'(t));
        pulse_event(1'b1);
        for (j = 1; j <= t + 1; j++) begin
            read_reg(ADDR_EIR, d);
            if (d[EIR_RXF_BIT] !== (j == t + 1)) begin
                report_mismatch($sformatf("EIR RXF %0d cycles after event", j),
                                32'(j == t + 1), 32'(d[EIR_RXF_BIT]));
            end
        end
        write_reg(ADDR_RXIC, '0);
        write_reg(ADDR_EIR, '1);
    endtask

    task automatic run_mdio_frame(input logic rd);
        int                    speed;
        int                    pre;
        int                    nbits;
        int                    cnt;
        int                    i;
        logic                  dis;
        logic                  done;
        logic                  exp_bit;
        logic [REG_DATA_W-1:0] frm;
        logic [REG_DATA_W-1:0] d;
        time                   per;
        speed = $urandom_range(1, 6);
        dis   = 1'($urandom_range(0, 1));
        frm   = $urandom;
        // ST 01, OP 10 read or 01 write, TA 10
        frm[31:28] = rd ? 4'b0110 : 4'b0101;
        frm[17:16] = 2'b10;
        write_reg(ADDR_ECR, 32'd1 << ECR_ETHEREN_BIT);
        write_reg(ADDR_MSCR, (32'(dis) << MSCR_DIS_PRE_BIT) | (32'(speed) << MII_SPEED_LSB));
        write_reg(ADDR_MMFR, frm);
        done = 1'b0;
        cnt  = 0;
        while (!done && cnt < 4000) begin
            read_reg(ADDR_EIR, d);
            done = d[EIR_MII_BIT];
            cnt++;
        end
        if (!done) begin
            timeouts++;
            $display("Timeout at %0t ns: the MDIO frame never set EIR MII", $time);
        end
        per = 2 * (speed + 1) * 40;
        if (min_period != per) report_mismatch("mdc period min", 32'(per), 32'(min_period));
        if (max_period != per) report_mismatch("mdc period max", 32'(per), 32'(max_period));
        pre   = dis ? 0 : MDIO_PREAMBLE_W;
        nbits = rd ? 14 : MDIO_FRAME_W;
        if (cap_bits.size() != pre + nbits) begin
            report_mismatch("mdo bit count", 32'(pre + nbits), 32'(cap_bits.size()));
        end else begin
            for (i = 0; i < pre + nbits; i++) begin
                exp_bit = (i < pre) ? 1'b1 : frm[31 - (i - pre)];
                if (cap_bits[i] !== exp_bit) begin
                    report_mismatch($sformatf("mdo bit %0d", i), 32'(exp_bit), 32'(cap_bits[i]));
                end
            end
        end
        if (rd) expect_reg(ADDR_MMFR, {frm[31:16], phy_data});
        else expect_reg(ADDR_MMFR, frm);
        write_reg(ADDR_EIR, '1);
    endtask

    task automatic check_no_frame(input logic en, input int speed);
        int                    rises0;
        logic                  seen_mii;
        logic [REG_DATA_W-1:0] d;
        write_reg(ADDR_ECR, en ? (32'd1 << ECR_ETHEREN_BIT) : 32'd0);
        write_reg(ADDR_MSCR, 32'(speed) << MII_SPEED_LSB);
        rises0   = mdc_rises;
        seen_mii = 1'b0;
        write_reg(ADDR_MMFR, {4'b0101, 28'($urandom)});
        repeat (600) begin
            read_reg(ADDR_EIR, d);
            if (d[EIR_MII_BIT] !== 1'b0) seen_mii = 1'b1;
        end
        if (seen_mii) report_mismatch("EIR MII after ignored start", 0, 1);
        if (mdc_rises != rises0) report_mismatch("mdc rising edges", 32'(rises0), 32'(mdc_rises));
    endtask

    initial begin
        logic [REG_ADDR_W-1:0] all_addr [8];
        logic [REG_ADDR_W-1:0] rw_addr [5];
        logic [REG_DATA_W-1:0] shadow [5];
        int                    i;
        void'($urandom(52474));
        all_addr = '{ADDR_EIR, ADDR_EIMR, ADDR_ECR, ADDR_MMFR, ADDR_MSCR, ADDR_TXIC,
                     ADDR_RXIC, 12'h3FC};
        rw_addr  = '{ADDR_EIMR, ADDR_ECR, ADDR_MSCR, ADDR_TXIC, ADDR_RXIC};
        clk        = 1'b0;
        rst_n      = 1'b0;
        reg_wr     = 1'b0;
        reg_rd     = 1'b0;
        reg_addr   = '0;
        reg_wdata  = '0;
        tx_frame   = 1'b0;
        rx_frame   = 1'b0;
        mdi        = 1'b1;
        errors     = 0;
        timeouts   = 0;
        mdc_q      = 1'b0;
        mdo_en_q   = 1'b0;
        mdc_rises  = 0;
        last_rise  = 0;
        min_period = '1;
        max_period = 0;
        phy_drive  = 1'b0;
        fall_cnt   = 0;
        phy_data   = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // reset values, an unmapped offset too
        for (i = 0; i < 8; i++) expect_reg(all_addr[i], '0);
        for (i = 0; i < 5; i++) begin
            shadow[i] = $urandom;
            write_reg(rw_addr[i], shadow[i]);
        end
        for (i = 0; i < 5; i++) begin
            expect_reg(rw_addr[i], shadow[i]);
            @(negedge clk);
            if (reg_rvalid !== 1'b0) report_mismatch("reg_rvalid", 32'd0, 32'(reg_rvalid));
        end
        for (i = 1; i < 5; i++) begin
            shadow[i] = '0;
            write_reg(rw_addr[i], '0);
        end
        shadow[0] = $urandom | (32'd1 << EIR_TXF_BIT);
        write_reg(ADDR_EIMR, shadow[0]);

        run_eir_random(400, shadow[0]);
        check_count_coalesce(1'b0);
        check_count_coalesce(1'b1);
        check_timer_coalesce();
        run_mdio_frame(1'b0);
        run_mdio_frame(1'b1);
        check_no_frame(1'b0, $urandom_range(1, 3));
        check_no_frame(1'b1, 0);

        $display("Run finished with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/enet_mgmt_core.sv */
`timescale 1ns/1ns
`default_nettype none

module enet_mgmt_core (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             reg_wr,
    input  wire                             reg_rd,
    input  wire [enet_pkg::REG_ADDR_W-1:0]  reg_addr,
    input  wire [enet_pkg::REG_DATA_W-1:0]  reg_wdata,
    output wire [enet_pkg::REG_DATA_W-1:0]  reg_rdata,
    output wire                             reg_rvalid,
    output wire                             irq,
    input  wire                             tx_frame,
    input  wire                             rx_frame,
    output wire                             mdc,
    input  wire                             mdi,
    output wire                             mdo,
    output wire                             mdo_en
);
    import enet_pkg::*;

    // coalescer configuration and pulses
    wire [REG_DATA_W-1:0]  txic;
    wire [REG_DATA_W-1:0]  rxic;
    wire                   txf_intr;
    wire                   rxf_intr;

    // mdio control and result
    wire                   frame_start;
    wire [REG_DATA_W-1:0]  frame;
    wire [MII_SPEED_W-1:0] mii_speed;
    wire                   dis_pre;
    wire                   ether_en;
    wire                   frame_done;
    wire                   rd_valid;
    wire [MMFR_DATA_W-1:0] rd_data;

    enet_regs u_enet_regs (
        .clk         (clk         ),
        .rst_n       (rst_n       ),
        .reg_wr      (reg_wr      ),
        .reg_rd      (reg_rd      ),
        .reg_addr    (reg_addr    ),
        .reg_wdata   (reg_wdata   ),
        .reg_rdata   (reg_rdata   ),
        .reg_rvalid  (reg_rvalid  ),
        .irq         (irq         ),
        .txic        (txic        ),
        .rxic        (rxic        ),
        .txf_intr    (txf_intr    ),
        .rxf_intr    (rxf_intr    ),
        .frame_start (frame_start ),
        .frame       (frame       ),
        .mii_speed   (mii_speed   ),
        .dis_pre     (dis_pre     ),
        .ether_en    (ether_en    ),
        .frame_done  (frame_done  ),
        .rd_valid    (rd_valid    ),
        .rd_data     (rd_data     )
    );

    enet_intr_coalesce u_tx_intr_coalesce (
        .clk      (clk      ),
        .rst_n    (rst_n    ),
        .ic_cfg   (txic     ),
        .event_in (tx_frame ),
        .intr     (txf_intr )
    );

    enet_intr_coalesce u_rx_intr_coalesce (
        .clk      (clk      ),
        .rst_n    (rst_n    ),
        .ic_cfg   (rxic     ),
        .event_in (rx_frame ),
        .intr     (rxf_intr )
    );

    enet_mdio u_enet_mdio (
        .clk         (clk         ),
        .rst_n       (rst_n       ),
        .ether_en    (ether_en    ),
        .mii_speed   (mii_speed   ),
        .dis_pre     (dis_pre     ),
        .frame_start (frame_start ),
        .frame       (frame       ),
        .mdi         (mdi         ),
        .mdc         (mdc         ),
        .mdo         (mdo         ),
        .mdo_en      (mdo_en      ),
        .frame_done  (frame_done  ),
        .rd_valid    (rd_valid    ),
        .rd_data     (rd_data     )
    );

endmodule

`default_nettype wire

/* mdio/enet_mdio.sv */
`timescale 1ns/1ns
`default_nettype none

module enet_mdio (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              ether_en,
    input  wire  [enet_pkg::MII_SPEED_W-1:0] mii_speed,
    input  wire                              dis_pre,
    input  wire                              frame_start,
    input  wire  [enet_pkg::MDIO_FRAME_W-1:0] frame,
    input  wire                              mdi,
    output logic                             mdc,
    output wire                              mdo,
    output logic                             mdo_en,
    output logic                             frame_done,
    output logic                             rd_valid,
    output logic [enet_pkg::MMFR_DATA_W-1:0] rd_data
);
    import enet_pkg::*;

    // preamble and frame travel through one shift register
    localparam int SHIFT_W   = MDIO_PREAMBLE_W + MDIO_FRAME_W;
    localparam int BIT_CNT_W = $clog2(SHIFT_W);
    // bit positions counted from the first preamble bit
    localparam int DATA_IDX  = SHIFT_W - MMFR_DATA_W;
    localparam int TA_IDX    = DATA_IDX - 2;

    logic                   busy;
    logic                   is_read;
    logic [MII_SPEED_W-1:0] speed_q;
    logic [MII_SPEED_W-1:0] div_cnt;
    logic [BIT_CNT_W-1:0]   bit_cnt;
    logic [SHIFT_W-1:0]     shift_q;
    logic                   start_ok;
    logic                   half_tick;
    logic                   mdc_rise;
    logic                   mdc_fall;
    logic                   last_bit;

    assign start_ok  = frame_start && !busy && ether_en && (mii_speed != '0);
    // mdc toggles every speed+1 clocks while a frame runs
    assign half_tick = busy && (div_cnt == speed_q);
    assign mdc_rise  = half_tick && !mdc;
    assign mdc_fall  = half_tick && mdc;
    assign last_bit  = (bit_cnt == BIT_CNT_W'(SHIFT_W - 1));
    assign mdo       = shift_q[SHIFT_W-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            is_read    <= 1'b0;
            speed_q    <= '0;
            div_cnt    <= '0;
            mdc        <= 1'b0;
            bit_cnt    <= '0;
            shift_q    <= '1;
            mdo_en     <= 1'b0;
            frame_done <= 1'b0;
            rd_valid   <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            rd_valid   <= 1'b0;
            if (busy && !ether_en) begin
                // abort, MII is not flagged
                busy    <= 1'b0;
                mdc     <= 1'b0;
                mdo_en  <= 1'b0;
                shift_q <= '1;
            end else if (start_ok) begin
                busy    <= 1'b1;
                speed_q <= mii_speed;
                div_cnt <= '0;
                mdc     <= 1'b0;
                mdo_en  <= 1'b1;
                is_read <= (frame[MMFR_OP_LSB +: 2] == 2'b10);
                if (dis_pre) begin
                    bit_cnt <= BIT_CNT_W'(MDIO_PREAMBLE_W);
                    shift_q <= {frame, {MDIO_PREAMBLE_W{1'b1}}};
                end else begin
                    bit_cnt <= '0;
                    shift_q <= {{MDIO_PREAMBLE_W{1'b1}}, frame};
                end
            end else if (busy) begin
                if (half_tick) begin
                    div_cnt <= '0;
                    mdc     <= ~mdc;
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
                // next bit goes out just after the falling edge
                if (mdc_fall) begin
                    shift_q <= {shift_q[SHIFT_W-2:0], 1'b1};
                    if (last_bit) begin
                        busy       <= 1'b0;
                        mdo_en     <= 1'b0;
                        frame_done <= 1'b1;
                        rd_valid   <= is_read;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (is_read && bit_cnt == BIT_CNT_W'(TA_IDX - 1)) begin
                            mdo_en <= 1'b0;
                        end
                    end
                end
            end
        end
    end

    // PHY drives data bits, taken on the rising edge
    always_ff @(posedge clk) begin
        if (mdc_rise && is_read && bit_cnt >= BIT_CNT_W'(DATA_IDX)) begin
            rd_data <= {rd_data[MMFR_DATA_W-2:0], mdi};
        end
    end

    // idle engine releases the line, parks mdc low and leaves mdo high
    a_idle_released: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> (!mdo_en && !mdc && mdo));

endmodule

`default_nettype wire

/* verilog/enet_intr_coalesce.sv */
`timescale 1ns/1ns
`default_nettype none

module enet_intr_coalesce (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire [enet_pkg::REG_DATA_W-1:0] ic_cfg,
    input  wire                            event_in,
    output logic                           intr
);
    import enet_pkg::*;

    logic                  ic_en;
    logic [IC_CNT_W-1:0]   cnt_thr;
    logic [IC_TIMER_W-1:0] timer_thr;
    logic [IC_CNT_W-1:0]   frame_cnt;
    logic [IC_CNT_W-1:0]   frame_cnt_next;
    logic [IC_TIMER_W-1:0] timer;
    logic [IC_TIMER_W-1:0] timer_next;
    logic                  pending;
    logic                  cnt_hit;
    logic                  timer_hit;

    assign ic_en     = ic_cfg[IC_EN_BIT];
    // a count threshold of zero behaves as one
    assign cnt_thr   = (ic_cfg[IC_CNT_LSB +: IC_CNT_W] == '0) ? IC_CNT_W'(1)
                                                             : ic_cfg[IC_CNT_LSB +: IC_CNT_W];
    assign timer_thr = ic_cfg[IC_TIMER_W-1:0];

    assign frame_cnt_next = frame_cnt + IC_CNT_W'(event_in);
    // timer reads 1 on the edge that takes the first event
    assign timer_next     = pending ? timer + 1'b1 : IC_TIMER_W'(event_in);
    assign cnt_hit        = event_in && (frame_cnt_next >= cnt_thr);
    assign timer_hit      = (timer_thr != '0) && (timer_next == timer_thr);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            intr      <= 1'b0;
            frame_cnt <= '0;
            timer     <= '0;
            pending   <= 1'b0;
        end else if (!ic_en) begin
            intr      <= event_in;
            frame_cnt <= '0;
            timer     <= '0;
            pending   <= 1'b0;
        end else if (cnt_hit || timer_hit) begin
            intr      <= 1'b1;
            frame_cnt <= '0;
            timer     <= '0;
            pending   <= 1'b0;
        end else begin
            intr      <= 1'b0;
            frame_cnt <= frame_cnt_next;
            timer     <= timer_next;
            pending   <= pending | event_in;
        end
    end

    // every pulse has an event or a pending event behind it
    a_intr_single: assert property (@(posedge clk) disable iff (!rst_n)
        intr |-> $past(event_in || pending));

endmodule

`default_nettype wire

/* verilog/enet_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module enet_regs (
    input  wire                              clk,
    input  wire                              rst_n,
    // host side
    input  wire                              reg_wr,
    input  wire                              reg_rd,
    input  wire  [enet_pkg::REG_ADDR_W-1:0]  reg_addr,
    input  wire  [enet_pkg::REG_DATA_W-1:0]  reg_wdata,
    output logic [enet_pkg::REG_DATA_W-1:0]  reg_rdata,
    output logic                             reg_rvalid,
    output logic                             irq,
    // coalescers
    output logic [enet_pkg::REG_DATA_W-1:0]  txic,
    output logic [enet_pkg::REG_DATA_W-1:0]  rxic,
    input  wire                              txf_intr,
    input  wire                              rxf_intr,
    // mdio engine
    output logic                             frame_start,
    output wire  [enet_pkg::REG_DATA_W-1:0]  frame,
    output wire  [enet_pkg::MII_SPEED_W-1:0] mii_speed,
    output wire                              dis_pre,
    output wire                              ether_en,
    input  wire                              frame_done,
    input  wire                              rd_valid,
    input  wire  [enet_pkg::MMFR_DATA_W-1:0] rd_data
);
    import enet_pkg::*;

    logic [REG_DATA_W-1:0] eir;
    logic [REG_DATA_W-1:0] eimr;
    logic [REG_DATA_W-1:0] ecr;
    logic [REG_DATA_W-1:0] mmfr;
    logic [REG_DATA_W-1:0] mscr;
    logic [REG_DATA_W-1:0] eir_set;
    logic [REG_DATA_W-1:0] eir_clr;
    logic [REG_DATA_W-1:0] rd_mux;
    logic                  wr_eir;
    logic                  wr_eimr;
    logic                  wr_ecr;
    logic                  wr_mmfr;
    logic                  wr_mscr;
    logic                  wr_txic;
    logic                  wr_rxic;

    assign wr_eir  = reg_wr && (reg_addr == ADDR_EIR);
    assign wr_eimr = reg_wr && (reg_addr == ADDR_EIMR);
    assign wr_ecr  = reg_wr && (reg_addr == ADDR_ECR);
    assign wr_mmfr = reg_wr && (reg_addr == ADDR_MMFR);
    assign wr_mscr = reg_wr && (reg_addr == ADDR_MSCR);
    assign wr_txic = reg_wr && (reg_addr == ADDR_TXIC);
    assign wr_rxic = reg_wr && (reg_addr == ADDR_RXIC);

    // only the three event sources ever reach EIR
    always_comb begin
        eir_set = '0;
        eir_set[EIR_TXF_BIT] = txf_intr;
        eir_set[EIR_RXF_BIT] = rxf_intr;
        eir_set[EIR_MII_BIT] = frame_done;
    end

    assign eir_clr = wr_eir ? reg_wdata : '0;

    assign frame     = mmfr;
    assign mii_speed = mscr[MII_SPEED_LSB +: MII_SPEED_W];
    assign dis_pre   = mscr[MSCR_DIS_PRE_BIT];
    assign ether_en  = ecr[ECR_ETHEREN_BIT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            eir         <= '0;
            eimr        <= '0;
            ecr         <= '0;
            mmfr        <= '0;
            mscr        <= '0;
            txic        <= '0;
            rxic        <= '0;
            frame_start <= 1'b0;
        end else begin
            // set beats a write-one-to-clear in the same cycle
            eir         <= eir_set | (eir & ~eir_clr);
            // mdio sees the new MMFR value together with the start pulse
            frame_start <= wr_mmfr;
            if (wr_eimr) eimr <= reg_wdata;
            if (wr_ecr)  ecr  <= reg_wdata;
            if (wr_mscr) mscr <= reg_wdata;
            if (wr_txic) txic <= reg_wdata;
            if (wr_rxic) rxic <= reg_wdata;
            if (wr_mmfr) begin
                mmfr <= reg_wdata;
            end else if (frame_done && rd_valid) begin
                mmfr[MMFR_DATA_W-1:0] <= rd_data;
            end
        end
    end

    always_comb begin
        case (reg_addr)
            ADDR_EIR:  rd_mux = eir;
            ADDR_EIMR: rd_mux = eimr;
            ADDR_ECR:  rd_mux = ecr;
            ADDR_MMFR: rd_mux = mmfr;
            ADDR_MSCR: rd_mux = mscr;
            ADDR_TXIC: rd_mux = txic;
            ADDR_RXIC: rd_mux = rxic;
            default:   rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reg_rd) begin
            reg_rdata <= rd_mux;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_rvalid <= 1'b0;
            irq        <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd;
            irq        <= |(eir & eimr);
        end
    end

    // host must not issue a read and a write together
    a_no_wr_rd: assert property (@(posedge clk) disable iff (!rst_n)
        !(reg_wr && reg_rd));

endmodule

`default_nettype wire

/* common/enet_pkg.sv */
`default_nettype none

package enet_pkg;

    // register bus
    localparam int REG_ADDR_W = 12;
    localparam int REG_DATA_W = 32;

    // register byte offsets
    localparam logic [REG_ADDR_W-1:0] ADDR_EIR  = 12'h004;
    localparam logic [REG_ADDR_W-1:0] ADDR_EIMR = 12'h008;
    localparam logic [REG_ADDR_W-1:0] ADDR_ECR  = 12'h024;
    localparam logic [REG_ADDR_W-1:0] ADDR_MMFR = 12'h040;
    localparam logic [REG_ADDR_W-1:0] ADDR_MSCR = 12'h044;
    localparam logic [REG_ADDR_W-1:0] ADDR_TXIC = 12'h0F0;
    localparam logic [REG_ADDR_W-1:0] ADDR_RXIC = 12'h100;

    // EIR event bits
    localparam int EIR_TXF_BIT = 27;
    localparam int EIR_RXF_BIT = 25;
    localparam int EIR_MII_BIT = 23;

    localparam int ECR_ETHEREN_BIT = 1;

    // TXIC / RXIC layout
    localparam int IC_EN_BIT  = 31;
    localparam int IC_CNT_LSB = 20;
    localparam int IC_CNT_W   = 8;
    localparam int IC_TIMER_W = 16;

    // MSCR fields
    localparam int MII_SPEED_LSB    = 1;
    localparam int MII_SPEED_W      = 6;
    localparam int MSCR_DIS_PRE_BIT = 7;

    // management frame, ST OP PA RA TA DATA sent MSB first
    localparam int MDIO_FRAME_W    = 32;
    localparam int MDIO_PREAMBLE_W = 32;
    // opcode 2'b10 is a read
    localparam int MMFR_OP_LSB     = 28;
    localparam int MMFR_DATA_W     = 16;

endpackage

`default_nettype wire
